//--- common/cromPkg.sv
// Control-ROM microword layout, special-function codes and dp bit fields the control blocks decode
package cromPkg;

   //////////////////////////////////////////////////
   // Special functions
   //////////////////////////////////////////////////

   typedef enum logic [3:0] {
      SPEC_NOP       = 4'h0,   // Nothing for these blocks
      SPEC_APRSET    = 4'h1,   // Load APR level and enables
      SPEC_APRCLR    = 4'h2,   // Clear APR flags
      SPEC_PISET     = 4'h3,   // Load PI on and level enables
      SPEC_PIGRANT   = 4'h4,   // Take the requested level
      SPEC_PIDISMISS = 4'h5,   // Drop the current level
      SPEC_CONSCLR   = 4'h6,   // Clear console exec and cont
      SPEC_HALT      = 4'h7    // Stop the processor
   } spec_t;

   // Microword slice seen by the control blocks
   typedef struct packed {
      spec_t      spec;        // Special function
      logic [3:0] spare;       // Rest of the ROM word, ignored here
   } cromWord_t;

   //////////////////////////////////////////////////
   // dp bit fields
   //////////////////////////////////////////////////

   // APRSET and APRCLR
   localparam int DP_APR_LEV_MSB = 24;   // APR level
   localparam int DP_APR_LEV_LSB = 26;
   localparam int DP_APR_EN_MSB  = 31;   // Enables or flags to clear
   localparam int DP_APR_EN_LSB  = 34;
   localparam int DP_APR_CSL     = 35;   // Console interrupt flag

   // PISET
   localparam int DP_PI_ON      = 28;    // PI system on
   localparam int DP_PI_LEV_MSB = 29;    // Level 1 enable
   localparam int DP_PI_LEV_LSB = 35;    // Level 7 enable

endpackage

//--- common/ks10Pkg.sv
// KS10 machine word, priority and interrupt types and timer constants used by the control blocks
package ks10Pkg;

   //////////////////////////////////////////////////
   // Datapath and interrupt types
   //////////////////////////////////////////////////

   typedef logic [0:35] word_t;        // 36-bit word with bit 0 as MSB
   typedef logic [0:2]  pri_t;         // Level 1 is highest and 0 means none
   typedef logic [1:7]  intrVec_t;     // One request bit per level

   localparam int PI_LEVELS = 7;       // Priority levels 1 to 7

   // APR flags in the same order as dp bits 31 to 34
   typedef struct packed {
      logic intCsl;                    // Interrupt to console
      logic timerDone;                 // Interval timer expired
      logic nxmErr;                    // Nonexistent memory
      logic cslReq;                    // Console asks for attention
   } aprFlags_t;

   // Flags able to raise the APR request
   localparam aprFlags_t APR_INTR_MASK = '{intCsl: 1'b0, timerDone: 1'b1,
                                           nxmErr: 1'b1, cslReq: 1'b1};

   localparam int TIMER_TICKS = 16;                   // Clocks per timer period
   localparam int TIMER_WIDTH = $clog2(TIMER_TICKS);  // Period counter width

   // One-hot request vector for a level, empty for level 0
   function automatic intrVec_t priToVec(pri_t pri);
      intrVec_t vec;
      for (int i = 1; i <= PI_LEVELS; i++) begin
         vec[i] = (pri == pri_t'(i));
      end
      return vec;
   endfunction

endpackage

//--- compile.f
common/ks10Pkg.sv
common/cromPkg.sv
src/intf.sv
src/timer.sv
src/apr.sv
pi/pi.sv
src/cpuCtl.sv
tb/tbClk.sv
tb/tbChecker.sv
tb/tbCpuCtl.sv

//--- pi/pi.sv
// Priority interrupt controller with level enables, active levels and request arbitration
module pi (
   input  logic               clkT,
   input  logic               rstN,
   input  logic               clkenDP,     // Datapath strobe
   input  cromPkg::cromWord_t crom,
   input  ks10Pkg::word_t     dp,          // Datapath bus
   input  ks10Pkg::intrVec_t  aprIntr,     // APR request
   input  ks10Pkg::intrVec_t  ubaIntr,     // Unibus requests
   output ks10Pkg::pri_t      piReqPri,    // Level asking for service
   output ks10Pkg::pri_t      piCurPri,    // Level being serviced
   output logic               piIntr
);

   import ks10Pkg::*;
   import cromPkg::*;

   logic     piOn;       // PI system on
   intrVec_t levelOn;    // Per-level enables
   intrVec_t active;     // Levels in service
   intrVec_t pending;    // Enabled requests
   intrVec_t eligible;   // Requests above the current level

   // Lowest-numbered set bit gives the level
   function automatic pri_t lowestLevel(intrVec_t vec);
      pri_t lev;
      lev = '0;
      for (int i = PI_LEVELS; i >= 1; i--) begin
         if (vec[i]) lev = pri_t'(i);
      end
      return lev;
   endfunction

   //////////////////////////////////////////////////
   // Arbitration
   //////////////////////////////////////////////////

   assign pending  = piOn ? ((aprIntr | ubaIntr) & levelOn) : '0;
   assign piCurPri = lowestLevel(active);

   // Only levels numerically below the current one may interrupt
   always_comb begin
      for (int i = 1; i <= PI_LEVELS; i++) begin
         eligible[i] = pending[i] && ((piCurPri == '0) || (pri_t'(i) < piCurPri));
      end
   end

   assign piReqPri = lowestLevel(eligible);
   assign piIntr   = (piReqPri != '0);

   //////////////////////////////////////////////////
   // PI registers
   //////////////////////////////////////////////////

   always_ff @(posedge clkT or negedge rstN) begin
      if (!rstN) begin
         piOn    <= 1'b0;
         levelOn <= '0;
         active  <= '0;
      end else if (clkenDP) begin
         case (crom.spec)
            SPEC_PISET: begin
               piOn    <= dp[DP_PI_ON];
               levelOn <= dp[DP_PI_LEV_MSB:DP_PI_LEV_LSB];   // dp 29 is level 1
            end
            SPEC_PIGRANT:   active <= active | priToVec(piReqPri);   // No-op when idle
            SPEC_PIDISMISS: active <= active & ~priToVec(piCurPri);  // Highest in service
            default: ;
         endcase
      end
   end

endmodule

//--- src/apr.sv
// APR flags, enables and level, producing the APR interrupt request and the console interrupt
module apr (
   input  logic               clkT,
   input  logic               rstN,
   input  logic               clkenDP,     // Datapath strobe
   input  cromPkg::cromWord_t crom,
   input  ks10Pkg::word_t     dp,          // Datapath bus
   input  logic               timerIntr,   // Timer period pulse
   input  logic               nxmIntr,     // Bus NXM pulse
   input  logic               cslIntrI,    // Console interrupt level
   output ks10Pkg::intrVec_t  aprIntr,     // Request at the APR level
   output logic               cslIntrO     // Interrupt to console
);

   import ks10Pkg::*;
   import cromPkg::*;

   aprFlags_t flags, flagsNxt;
   aprFlags_t enables, enablesNxt;
   pri_t      level, levelNxt;
   intrVec_t  intrNxt;
   logic      doSet, doClr;

   assign doSet = clkenDP && (crom.spec == SPEC_APRSET);
   assign doClr = clkenDP && (crom.spec == SPEC_APRCLR);

   //////////////////////////////////////////////////
   // Next flags, enables and level
   //////////////////////////////////////////////////

   always_comb begin
      flagsNxt   = flags;
      enablesNxt = enables;
      levelNxt   = level;
      if (doSet) begin
         enablesNxt = aprFlags_t'(dp[DP_APR_EN_MSB:DP_APR_EN_LSB]);
         levelNxt   = dp[DP_APR_LEV_MSB:DP_APR_LEV_LSB];
         if (dp[DP_APR_CSL]) flagsNxt.intCsl = 1'b1;
      end
      if (doClr) begin
         flagsNxt = flagsNxt & ~aprFlags_t'(dp[DP_APR_EN_MSB:DP_APR_EN_LSB]);
         if (dp[DP_APR_CSL]) flagsNxt.intCsl = 1'b0;
      end
      // Hardware events beat a clear in the same cycle
      if (timerIntr) flagsNxt.timerDone = 1'b1;
      if (nxmIntr)   flagsNxt.nxmErr    = 1'b1;
      flagsNxt.cslReq = cslIntrI;              // Just a one-cycle copy
      // Request follows the new flags so both move together
      if (|(flagsNxt & enablesNxt & APR_INTR_MASK)) begin
         intrNxt = priToVec(levelNxt);          // Empty at level 0
      end else begin
         intrNxt = '0;
      end
   end

   always_ff @(posedge clkT or negedge rstN) begin
      if (!rstN) begin
         flags   <= '0;
         enables <= '0;
         level   <= '0;
         aprIntr <= '0;
      end else begin
         flags   <= flagsNxt;
         enables <= enablesNxt;
         level   <= levelNxt;
         aprIntr <= intrNxt;
      end
   end

   assign cslIntrO = flags.intCsl;

endmodule

//--- src/cpuCtl.sv
// Control-side top level joining the console interface, interval timer, APR and PI controller
module cpuCtl (
   input  logic               clkT,
   input  logic               rstN,
   input  logic               clkenDP,     // Datapath strobe
   input  cromPkg::cromWord_t crom,        // Microword from the sequencer
   input  ks10Pkg::word_t     dp,          // Datapath bus
   input  logic               cslSet,
   input  logic               cslRun,
   input  logic               cslExec,
   input  logic               cslCont,
   input  logic               cslTimerEn,
   input  logic               cslIntrI,
   input  logic               nxmIntr,
   input  ks10Pkg::intrVec_t  ubaIntr,
   output logic               cpuRun,
   output logic               cpuExec,
   output logic               cpuCont,
   output logic               cpuHalt,
   output logic               cslIntrO,
   output logic               piIntr,
   output ks10Pkg::pri_t      piReqPri,
   output ks10Pkg::pri_t      piCurPri
);

   import ks10Pkg::*;

   logic     timerIntr;   // Timer to APR
   intrVec_t aprIntr;     // APR to PI

   intf uIntf (
      .clkT    (clkT),
      .rstN    (rstN),
      .clkenDP (clkenDP),
      .crom    (crom),
      .cslSet  (cslSet),
      .cslRun  (cslRun),
      .cslExec (cslExec),
      .cslCont (cslCont),
      .cpuRun  (cpuRun),
      .cpuExec (cpuExec),
      .cpuCont (cpuCont),
      .cpuHalt (cpuHalt)
   );

   timer uTimer (
      .clkT      (clkT),
      .rstN      (rstN),
      .timerEn   (cslTimerEn),
      .timerIntr (timerIntr)
   );

   apr uApr (
      .clkT      (clkT),
      .rstN      (rstN),
      .clkenDP   (clkenDP),
      .crom      (crom),
      .dp        (dp),
      .timerIntr (timerIntr),
      .nxmIntr   (nxmIntr),
      .cslIntrI  (cslIntrI),
      .aprIntr   (aprIntr),
      .cslIntrO  (cslIntrO)
   );

   pi uPi (
      .clkT     (clkT),
      .rstN     (rstN),
      .clkenDP  (clkenDP),
      .crom     (crom),
      .dp       (dp),
      .aprIntr  (aprIntr),
      .ubaIntr  (ubaIntr),
      .piReqPri (piReqPri),
      .piCurPri (piCurPri),
      .piIntr   (piIntr)
   );

endmodule

//--- src/intf.sv
// Console run, exec, continue and halt status, loaded by the console and changed by microcode
module intf (
   input  logic               clkT,
   input  logic               rstN,
   input  logic               clkenDP,    // Datapath strobe
   input  cromPkg::cromWord_t crom,
   input  logic               cslSet,     // Console load strobe
   input  logic               cslRun,
   input  logic               cslExec,
   input  logic               cslCont,
   output logic               cpuRun,
   output logic               cpuExec,
   output logic               cpuCont,
   output logic               cpuHalt
);

   import cromPkg::*;

   // Console status bits kept together
   typedef struct packed {
      logic run;
      logic exec;
      logic cont;
      logic halt;
   } cslState_t;

   cslState_t state;

   //////////////////////////////////////////////////
   // Status register
   //////////////////////////////////////////////////

   always_ff @(posedge clkT or negedge rstN) begin
      if (!rstN) begin
         state <= '0;
      end else if (cslSet) begin              // Console wins over microcode
         state.run  <= cslRun;
         state.exec <= cslExec;
         state.cont <= cslCont;
         if (cslRun) begin
            state.halt <= 1'b0;               // Restart leaves halt
         end
      end else if (clkenDP) begin
         case (crom.spec)
            SPEC_CONSCLR: begin
               state.exec <= 1'b0;
               state.cont <= 1'b0;
            end
            SPEC_HALT: begin
               state.run  <= 1'b0;
               state.halt <= 1'b1;
            end
            default: ;                        // Other functions belong elsewhere
         endcase
      end
   end

   assign cpuRun  = state.run;
   assign cpuExec = state.exec;
   assign cpuCont = state.cont;
   assign cpuHalt = state.halt;

endmodule

//--- src/timer.sv
// Interval timer that counts clocks while enabled and pulses an interrupt once per period
module timer (
   input  logic clkT,
   input  logic rstN,
   input  logic timerEn,      // Console timer enable
   output logic timerIntr     // One-cycle pulse per period
);

   import ks10Pkg::*;

   logic [TIMER_WIDTH-1:0] count;   // Period counter
   logic                   wrap;    // Last tick of the period

   // Period ends on the last count
   assign wrap = (count == TIMER_WIDTH'(TIMER_TICKS - 1));

   //////////////////////////////////////////////////
   // Period counter and pulse
   //////////////////////////////////////////////////

   always_ff @(posedge clkT or negedge rstN) begin
      if (!rstN) begin
         count     <= '0;
         timerIntr <= 1'b0;
      end else if (!timerEn) begin
         count     <= '0;                    // Held at zero while off
         timerIntr <= 1'b0;
      end else begin
         if (wrap) begin
            count <= '0;
         end else begin
            count <= count + 1'b1;
         end
         timerIntr <= wrap;                  // High in the cycle after the wrap
      end
   end

endmodule

//--- tb/tbChecker.sv
// Testbench checker that samples the DUT outputs on request, compares them and keeps the counts
module tbChecker (
   input logic          cpuRun,
   input logic          cpuExec,
   input logic          cpuCont,
   input logic          cpuHalt,
   input logic          cslIntrO,
   input logic          piIntr,
   input ks10Pkg::pri_t piReqPri,
   input ks10Pkg::pri_t piCurPri
);

   timeunit 1ns;
   timeprecision 100ps;

   import ks10Pkg::*;

   int passCount = 0;
   int failCount = 0;

   // Text for one wrong signal, empty when it matches
   function automatic string fieldMismatch(string sig, logic [3:0] exp, logic [3:0] act);
      if (act !== exp) begin
         return $sformatf(" %s expected 0x%h got 0x%h;", sig, exp, act);
      end
      return "";
   endfunction

   //////////////////////////////////////////////////
   // Compare one test's outputs
   //////////////////////////////////////////////////

   task automatic compareOutputs(input string test, input logic expIntr, input pri_t expReq,
                                 input pri_t expCur, input logic [4:0] expCsl);
      string errs;
      errs = "";
      errs = {errs, fieldMismatch("piIntr",   4'(expIntr),    4'(piIntr))};
      errs = {errs, fieldMismatch("piReqPri", 4'(expReq),     4'(piReqPri))};
      errs = {errs, fieldMismatch("piCurPri", 4'(expCur),     4'(piCurPri))};
      errs = {errs, fieldMismatch("cpuRun",   4'(expCsl[4]),  4'(cpuRun))};   // Console bits
      errs = {errs, fieldMismatch("cpuExec",  4'(expCsl[3]),  4'(cpuExec))};
      errs = {errs, fieldMismatch("cpuCont",  4'(expCsl[2]),  4'(cpuCont))};
      errs = {errs, fieldMismatch("cpuHalt",  4'(expCsl[1]),  4'(cpuHalt))};
      errs = {errs, fieldMismatch("cslIntrO", 4'(expCsl[0]),  4'(cslIntrO))};
      if (errs == "") begin
         passCount++;
         $display("[PASS] %s", test);
      end else begin
         failCount++;
         $display("[FAIL] %s:%s", test, errs);   // Every wrong signal on the one line
      end
   endtask

   task automatic reportCounts();
      $display("Tests run %0d, passed %0d, failed %0d",
               passCount + failCount, passCount, failCount);
   endtask

endmodule

//--- tb/tbClk.sv
// Testbench clock and reset source, 8 ns clkT with rstN held low for the first three cycles
module tbClk (
   output logic clkT,
   output logic rstN
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clkT = 1'b0;
      forever #4 clkT = ~clkT;          // 8 ns period
   end

   initial begin
      rstN = 1'b0;
      repeat (3) @(posedge clkT);
      @(negedge clkT);                  // Release away from the active edge
      rstN = 1'b1;
   end

endmodule

//--- tb/tbCpuCtl.sv
// Testbench top that builds the stimulus table and plays the microsequencer and console
module tbCpuCtl;

   timeunit 1ns;
   timeprecision 100ps;

   import ks10Pkg::*;
   import cromPkg::*;

   localparam int MAX_ENTRIES = 48;

   typedef enum logic [2:0] {ACT_NONE, ACT_UWORD, ACT_CSL, ACT_UBA, ACT_NXM, ACT_TIMER} action_t;

   typedef struct packed {
      action_t    act;
      spec_t      spec;          // Special function for ACT_UWORD
      word_t      dp;
      logic [2:0] csl;           // Run, exec, cont
      intrVec_t   uba;
      logic       timerOn;
      logic [5:0] waitCycles;    // Extra cycles before the check
   } stim_t;

   typedef struct packed {
      logic       piIntr;
      pri_t       piReqPri;
      pri_t       piCurPri;
      logic [4:0] csl;           // Run, exec, cont, halt, cslIntrO
   } expect_t;

   typedef struct packed {
      stim_t   stim;
      expect_t exp;
   } entry_t;

   logic clkT, rstN, clkenDP, cslSet, cslRun, cslExec, cslCont;
   logic cslTimerEn, cslIntrI, nxmIntr;
   logic cpuRun, cpuExec, cpuCont, cpuHalt, cslIntrO, piIntr;
   cromWord_t crom;
   word_t     dp;
   intrVec_t  ubaIntr;
   pri_t      piReqPri, piCurPri;

   entry_t stimTable [MAX_ENTRIES];
   string  testName  [MAX_ENTRIES];
   int     nEntries = 0;
   int     maxWait  = 0;
   logic   tableReady = 1'b0;
   integer seed;

   // Reference state built from the behavior rules
   logic      mRun, mExec, mCont, mHalt, mPiOn;
   aprFlags_t mFlags, mEn;
   pri_t      mLevel;
   intrVec_t  mLevelOn, mActive, mUba;

   tbClk uClk (.clkT(clkT), .rstN(rstN));

   cpuCtl u_dut (
      .clkT(clkT), .rstN(rstN), .clkenDP(clkenDP), .crom(crom), .dp(dp),
      .cslSet(cslSet), .cslRun(cslRun), .cslExec(cslExec), .cslCont(cslCont),
      .cslTimerEn(cslTimerEn), .cslIntrI(cslIntrI), .nxmIntr(nxmIntr), .ubaIntr(ubaIntr),
      .cpuRun(cpuRun), .cpuExec(cpuExec), .cpuCont(cpuCont), .cpuHalt(cpuHalt),
      .cslIntrO(cslIntrO), .piIntr(piIntr), .piReqPri(piReqPri), .piCurPri(piCurPri)
   );

   tbChecker uChk (
      .cpuRun(cpuRun), .cpuExec(cpuExec), .cpuCont(cpuCont), .cpuHalt(cpuHalt),
      .cslIntrO(cslIntrO), .piIntr(piIntr), .piReqPri(piReqPri), .piCurPri(piCurPri)
   );

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic pri_t firstLevel(intrVec_t vec);
      for (int i = 1; i <= 7; i++) begin
         if (vec[i]) return pri_t'(i);     // Level 1 wins
      end
      return '0;
   endfunction

   // APR request vector: one bit at the APR level when an enabled flag is up
   function automatic intrVec_t aprRequest();
      intrVec_t vec;
      logic     any;
      vec = '0;
      any = (mFlags.timerDone & mEn.timerDone) | (mFlags.nxmErr & mEn.nxmErr)
          | (mFlags.cslReq & mEn.cslReq);
      for (int i = 1; i <= 7; i++) begin
         if (any && mLevel == pri_t'(i)) vec[i] = 1'b1;
      end
      return vec;
   endfunction

   // Lowest pending level above the one in service
   function automatic pri_t requestLevel();
      intrVec_t pend;
      pri_t     cur;
      pend = mPiOn ? ((aprRequest() | mUba) & mLevelOn) : '0;
      cur  = firstLevel(mActive);
      for (int i = 1; i <= 7; i++) begin
         if (pend[i] && (cur == '0 || pri_t'(i) < cur)) return pri_t'(i);
      end
      return '0;
   endfunction

   task automatic updateModel(input stim_t s);
      pri_t lev;
      case (s.act)
         ACT_CSL: begin
            {mRun, mExec, mCont} = s.csl;
            if (s.csl[2]) mHalt = 1'b0;
         end
         ACT_UBA:   mUba = s.uba;
         ACT_NXM:   mFlags.nxmErr = 1'b1;
         ACT_TIMER: if (s.timerOn) mFlags.timerDone = 1'b1;   // Wait spans a full period
         ACT_UWORD: begin
            case (s.spec)
               SPEC_CONSCLR: {mExec, mCont} = 2'b00;
               SPEC_HALT:    {mRun, mHalt}  = 2'b01;
               SPEC_APRSET: begin
                  mLevel = s.dp[DP_APR_LEV_MSB:DP_APR_LEV_LSB];
                  mEn    = aprFlags_t'(s.dp[DP_APR_EN_MSB:DP_APR_EN_LSB]);
                  if (s.dp[DP_APR_CSL]) mFlags.intCsl = 1'b1;
               end
               SPEC_APRCLR: begin
                  mFlags = mFlags & ~aprFlags_t'(s.dp[DP_APR_EN_MSB:DP_APR_EN_LSB]);
                  if (s.dp[DP_APR_CSL]) mFlags.intCsl = 1'b0;
               end
               SPEC_PISET: begin
                  mPiOn    = s.dp[DP_PI_ON];
                  mLevelOn = s.dp[DP_PI_LEV_MSB:DP_PI_LEV_LSB];
               end
               SPEC_PIGRANT: begin
                  lev = requestLevel();
                  if (lev != '0) mActive[lev] = 1'b1;
               end
               SPEC_PIDISMISS: begin
                  lev = firstLevel(mActive);
                  if (lev != '0) mActive[lev] = 1'b0;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   endtask

   //////////////////////////////////////////////////
   // Table building
   //////////////////////////////////////////////////

   task automatic addStep(input action_t act, input spec_t spec, input word_t d,
                          input logic [2:0] csl, input intrVec_t uba, input logic tOn,
                          input int waitCycles, input string name);
      entry_t e;
      e.stim = '{act, spec, d, csl, uba, tOn, 6'(waitCycles)};
      updateModel(e.stim);
      e.exp.piReqPri = requestLevel();
      e.exp.piIntr   = (e.exp.piReqPri != '0);
      e.exp.piCurPri = firstLevel(mActive);
      e.exp.csl      = {mRun, mExec, mCont, mHalt, mFlags.intCsl};
      stimTable[nEntries] = e;
      testName[nEntries]  = name;
      nEntries++;
      if (waitCycles > maxWait) maxWait = waitCycles;
   endtask

   task automatic addUword(input spec_t spec, input word_t d, input string name);
      addStep(ACT_UWORD, spec, d, 3'b000, '0, 1'b0, 0, name);
   endtask

   task automatic addUba(input intrVec_t uba, input string name);
      addStep(ACT_UBA, SPEC_NOP, '0, 3'b000, uba, 1'b0, 0, name);
   endtask

   task automatic buildTable();
      word_t d;
      {mRun, mExec, mCont, mHalt, mPiOn} = '0;
      {mFlags, mEn, mLevel, mLevelOn, mActive, mUba} = '0;
      addStep(ACT_NONE, SPEC_NOP, '0, 3'b000, '0, 1'b0, 0, "reset state");
      addStep(ACT_CSL, SPEC_NOP, '0, 3'b111, '0, 1'b0, 0, "console run exec cont");
      addUword(SPEC_CONSCLR, '0, "consclr drops exec");
      addUword(SPEC_HALT, '0, "halt");
      addStep(ACT_CSL, SPEC_NOP, '0, 3'b100, '0, 1'b0, 0, "console run clears halt");
      d = '0;
      d[DP_APR_CSL] = 1'b1;
      addUword(SPEC_APRSET, d, "aprset console intr");
      addUword(SPEC_APRCLR, d, "aprclr console intr");
      d = '0;
      d[DP_PI_ON] = 1'b1;
      d[DP_PI_LEV_MSB:DP_PI_LEV_LSB] = 7'b1011010;     // Levels 1, 3, 4 and 6 on
      addUword(SPEC_PISET, d, "piset");
      for (int i = 0; i < 10; i++) begin
         addUba(intrVec_t'($random(seed)), $sformatf("pi random %0d", i));
      end
      addUba(7'b0100000, "level 2 off ignored");
      addUba(7'b0010010, "request 3 and 6");
      addUword(SPEC_PIGRANT, '0, "grant 3");
      addUba(7'b1010010, "request 1 above 3");
      addUword(SPEC_PIGRANT, '0, "grant 1");
      addUword(SPEC_PIDISMISS, '0, "dismiss back to 3");
      addUba(7'b0010010, "drop request 1");
      addUword(SPEC_PIDISMISS, '0, "dismiss to idle");
      addUba('0, "no requests");
      d = '0;
      d[DP_APR_LEV_MSB:DP_APR_LEV_LSB] = 3'd3;
      d[32] = 1'b1;                                    // timerDone enable
      d[33] = 1'b1;                                    // nxmErr enable
      addUword(SPEC_APRSET, d, "apr level 3");
      addStep(ACT_TIMER, SPEC_NOP, '0, 3'b000, '0, 1'b1, TIMER_TICKS + 2, "timer expires");
      addStep(ACT_TIMER, SPEC_NOP, '0, 3'b000, '0, 1'b0, 0, "timer off");
      d = '0;
      d[32] = 1'b1;
      addUword(SPEC_APRCLR, d, "aprclr timer done");
      addStep(ACT_NXM, SPEC_NOP, '0, 3'b000, '0, 1'b0, 0, "nxm raises level 3");
   endtask

   //////////////////////////////////////////////////
   // Stimulus loop
   //////////////////////////////////////////////////

   task automatic driveStim(input stim_t s);
      case (s.act)
         ACT_UWORD: begin
            clkenDP   = 1'b1;
            crom.spec = s.spec;
            dp        = s.dp;
         end
         ACT_CSL: begin
            cslSet = 1'b1;
            {cslRun, cslExec, cslCont} = s.csl;
         end
         ACT_UBA:   ubaIntr    = s.uba;
         ACT_NXM:   nxmIntr    = 1'b1;
         ACT_TIMER: cslTimerEn = s.timerOn;
         default: ;
      endcase
   endtask

   initial begin
      clkenDP    = 1'b0;
      crom       = '{spec: SPEC_NOP, spare: 4'hf};     // Spare bits must not matter
      dp         = '0;
      {cslSet, cslRun, cslExec, cslCont} = '0;
      {cslTimerEn, cslIntrI, nxmIntr}    = '0;
      ubaIntr    = '0;
      seed       = 32'he7fb_0af5;
      buildTable();
      tableReady = 1'b1;
      wait (rstN === 1'b1);
      for (int i = 0; i < nEntries; i++) begin
         @(negedge clkT);
         driveStim(stimTable[i].stim);
         @(posedge clkT);
         @(negedge clkT);
         clkenDP   = 1'b0;                             // Strobes last one cycle
         cslSet    = 1'b0;
         nxmIntr   = 1'b0;
         crom.spec = SPEC_NOP;
         dp        = '0;
         repeat (stimTable[i].stim.waitCycles) @(negedge clkT);
         uChk.compareOutputs(testName[i], stimTable[i].exp.piIntr, stimTable[i].exp.piReqPri,
                             stimTable[i].exp.piCurPri, stimTable[i].exp.csl);
      end
      uChk.reportCounts();
      if (uChk.failCount == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // Watchdog sized from the table
   initial begin
      int limitNs;
      wait (tableReady === 1'b1);
      limitNs = nEntries * (maxWait + 4) * 8;
      #(limitNs);
      $display("Timeout: the test loop did not finish within %0d ns", limitNs);
      $display("TB FAILED");
      $finish;
   end

endmodule
